/* list.f */
+incdir+source
source/issue_pkg.sv
source/psel_gen.sv
source/issue_if.sv
source/rs_table.sv
source/issue_select.sv
source/issue_unit_top.sv
verification/tb_clock.sv
verification/issue_props.sv
verification/issue_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the issue unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --assert --timescale 1ns/10ps -f list.f \
  --top-module issue_unit_tb -o issue_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/issue_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation passed"
exit 0

/* source/issue_defs.svh */
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// reservation station depth
`define RS_SIZE 8

// issue lanes leaving the selector each cycle
`define ISSUE_WIDTH 3

// physical register tag width
`define TAG_W 6

// opcode field width
`define OP_W 5

`endif

/* source/issue_if.sv */
`timescale 1ns/10ps
`include "issue_defs.svh"

interface issue_if;
  import issue_pkg::*;

  // entry is valid with both sources ready
  rs_vec_t ready;

  // per-entry payload as stored in the table
  opcode_t opcode [`RS_SIZE];
  tag_t    dest   [`RS_SIZE];
  tag_t    src1   [`RS_SIZE];
  tag_t    src2   [`RS_SIZE];

  // entries taken by any lane this cycle, cleared at the next edge
  rs_vec_t grant;

  modport tbl    (output ready, opcode, dest, src1, src2, input grant);
  modport select (input ready, opcode, dest, src1, src2, output grant);
  modport props  (input ready, opcode, dest, src1, src2, grant);

endinterface

/* source/issue_pkg.sv */
`include "issue_defs.svh"

package issue_pkg;

  // physical register tag, as carried by dispatch and the cdb
  typedef logic [`TAG_W-1:0] tag_t;

  // operation code, passed through untouched
  typedef logic [`OP_W-1:0] opcode_t;

  // one bit per reservation station entry
  // used for ready, free and grant vectors
  typedef logic [`RS_SIZE-1:0] rs_vec_t;

  // one bit per issue lane
  typedef logic [`ISSUE_WIDTH-1:0] lane_vec_t;

endpackage

/* source/issue_select.sv */
`timescale 1ns/10ps
`include "issue_defs.svh"

module issue_select (
  input  logic                clock,
  input  logic                rst,
  issue_if.select             sel,
  output issue_pkg::lane_vec_t issue_valid,
  output issue_pkg::opcode_t  issue_opcode [`ISSUE_WIDTH],
  output issue_pkg::tag_t     issue_dest   [`ISSUE_WIDTH],
  output issue_pkg::tag_t     issue_src1   [`ISSUE_WIDTH],
  output issue_pkg::tag_t     issue_src2   [`ISSUE_WIDTH]
);
  import issue_pkg::*;

  // one-hot grant per lane over the table entries
  logic [`ISSUE_WIDTH-1:0][`RS_SIZE-1:0] lane_gnt;

  // next-state of the issue register
  lane_vec_t valid_d;
  opcode_t   op_d   [`ISSUE_WIDTH];
  tag_t      dest_d [`ISSUE_WIDTH];
  tag_t      src1_d [`ISSUE_WIDTH];
  tag_t      src2_d [`ISSUE_WIDTH];

  // lane 0 lowest, lane 1 highest, lane 2 lowest of the rest
  psel_gen #(
    .REQS  (`ISSUE_WIDTH),
    .WIDTH (`RS_SIZE)
  ) u_lane_sel (
    .req     (sel.ready),
    .gnt     (sel.grant),
    .gnt_bus (lane_gnt),
    .empty   ()
  );

  // grants are one-hot so an OR of the masked entries picks each lane payload
  always_comb begin
    for (int l = 0; l < `ISSUE_WIDTH; l++) begin
      // a lane fires whenever it holds a grant
      valid_d[l]  = |lane_gnt[l];
      op_d[l]     = '0;
      dest_d[l]   = '0;
      src1_d[l]   = '0;
      src2_d[l]   = '0;
      for (int i = 0; i < `RS_SIZE; i++) begin
        if (lane_gnt[l][i]) begin
          op_d[l]   = op_d[l] | sel.opcode[i];
          dest_d[l] = dest_d[l] | sel.dest[i];
          src1_d[l] = src1_d[l] | sel.src1[i];
          src2_d[l] = src2_d[l] | sel.src2[i];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      issue_valid <= '0;
    end else begin
      issue_valid <= valid_d;
    end
  end

  // payload only loads on a live lane
  always_ff @(posedge clock) begin
    for (int l = 0; l < `ISSUE_WIDTH; l++) begin
      if (valid_d[l]) begin
        issue_opcode[l] <= op_d[l];
        issue_dest[l]   <= dest_d[l];
        issue_src1[l]   <= src1_d[l];
        issue_src2[l]   <= src2_d[l];
      end
    end
  end

endmodule

/* source/issue_unit_top.sv */
`timescale 1ns/10ps
`include "issue_defs.svh"

module issue_unit_top (
  input  logic                 clock,
  input  logic                 rst,
  input  logic                 dispatch_valid,
  input  issue_pkg::opcode_t   dispatch_opcode,
  input  issue_pkg::tag_t      dispatch_dest,
  input  issue_pkg::tag_t      dispatch_src1,
  input  logic                 dispatch_src1_ready,
  input  issue_pkg::tag_t      dispatch_src2,
  input  logic                 dispatch_src2_ready,
  input  logic                 cdb_valid,
  input  issue_pkg::tag_t      cdb_tag,
  output logic                 rs_full,
  output issue_pkg::lane_vec_t issue_valid,
  output issue_pkg::opcode_t   issue_opcode [`ISSUE_WIDTH],
  output issue_pkg::tag_t      issue_dest   [`ISSUE_WIDTH],
  output issue_pkg::tag_t      issue_src1   [`ISSUE_WIDTH],
  output issue_pkg::tag_t      issue_src2   [`ISSUE_WIDTH]
);

  // ready vector, payloads and grants between the two stages
  issue_if u_if ();

  // stage 1, entry storage with allocation and wakeup
  rs_table u_rs_table (
    .clock               (clock),
    .rst                 (rst),
    .dispatch_valid      (dispatch_valid),
    .dispatch_opcode     (dispatch_opcode),
    .dispatch_dest       (dispatch_dest),
    .dispatch_src1       (dispatch_src1),
    .dispatch_src1_ready (dispatch_src1_ready),
    .dispatch_src2       (dispatch_src2),
    .dispatch_src2_ready (dispatch_src2_ready),
    .cdb_valid           (cdb_valid),
    .cdb_tag             (cdb_tag),
    .rs_full             (rs_full),
    .tbl                 (u_if.tbl)
  );

  // stage 2, selector and issue register
  issue_select u_issue_select (
    .clock        (clock),
    .rst          (rst),
    .sel          (u_if.select),
    .issue_valid  (issue_valid),
    .issue_opcode (issue_opcode),
    .issue_dest   (issue_dest),
    .issue_src1   (issue_src1),
    .issue_src2   (issue_src2)
  );

endmodule

/* source/psel_gen.sv */
`timescale 1ns/10ps

module psel_gen #(
  parameter int REQS  = 3,
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0]            req,
  output logic [WIDTH-1:0]            gnt,
  output logic [REQS-1:0][WIDTH-1:0]  gnt_bus,
  output logic                        empty
);

  // requests still open while walking the grant lines
  logic [WIDTH-1:0] remain;

  // single-grant selector
  // isolates the lowest set bit, or the highest one when from_top is set
  function automatic logic [WIDTH-1:0] pick_one(
    input logic [WIDTH-1:0] v,
    input logic             from_top
  );
    logic [WIDTH-1:0] r;
    logic [WIDTH-1:0] g;
    logic [WIDTH-1:0] res;
    // reverse bit order for highest-first search
    for (int k = 0; k < WIDTH; k++) begin
      r[k] = from_top ? v[WIDTH-1-k] : v[k];
    end
    // two's complement trick keeps only the lowest one
    g = r & (~r + WIDTH'(1));
    // undo the reversal so the grant lines up with req
    for (int k = 0; k < WIDTH; k++) begin
      res[k] = from_top ? g[WIDTH-1-k] : g[k];
    end
    return res;
  endfunction

  // nothing requested at all
  assign empty = ~(|req);

  // grant lines alternate direction
  // even lines take lowest remaining, odd lines take highest remaining
  always_comb begin
    remain = req;
    gnt    = '0;
    for (int j = 0; j < REQS; j++) begin
      gnt_bus[j] = pick_one(remain, (j % 2) != 0);
      // later lines never see a bit already granted
      remain     = remain & ~gnt_bus[j];
      // combined grant vector over all lines
      gnt        = gnt | gnt_bus[j];
    end
  end

endmodule

/* source/rs_table.sv */
`timescale 1ns/10ps
`include "issue_defs.svh"

module rs_table (
  input  logic              clock,
  input  logic              rst,
  input  logic              dispatch_valid,
  input  issue_pkg::opcode_t dispatch_opcode,
  input  issue_pkg::tag_t   dispatch_dest,
  input  issue_pkg::tag_t   dispatch_src1,
  input  logic              dispatch_src1_ready,
  input  issue_pkg::tag_t   dispatch_src2,
  input  logic              dispatch_src2_ready,
  input  logic              cdb_valid,
  input  issue_pkg::tag_t   cdb_tag,
  output logic              rs_full,
  issue_if.tbl              tbl
);
  import issue_pkg::*;

  // control state per entry
  rs_vec_t valid;
  rs_vec_t s1_rdy;
  rs_vec_t s2_rdy;

  // payload per entry
  opcode_t op_q   [`RS_SIZE];
  tag_t    dest_q [`RS_SIZE];
  tag_t    src1_q [`RS_SIZE];
  tag_t    src2_q [`RS_SIZE];

  // allocation
  rs_vec_t free_vec;
  rs_vec_t alloc_oh;
  logic    no_free;
  logic    alloc_en;

  // cdb hitting the instruction being dispatched right now
  logic    wake1_new;
  logic    wake2_new;

  assign free_vec = ~valid;

  // lowest-index free entry, single grant line
  psel_gen #(
    .REQS  (1),
    .WIDTH (`RS_SIZE)
  ) u_free_sel (
    .req     (free_vec),
    .gnt     (alloc_oh),
    .gnt_bus (),
    .empty   (no_free)
  );

  assign rs_full  = no_free;
  // dispatch while full is dropped
  assign alloc_en = dispatch_valid & ~no_free;

  assign wake1_new = cdb_valid && (dispatch_src1 == cdb_tag);
  assign wake2_new = cdb_valid && (dispatch_src2 == cdb_tag);

  // grant only ever hits valid entries and alloc only free ones,
  // so the three cases per entry never overlap
  always_ff @(posedge clock) begin
    if (rst) begin
      valid  <= '0;
      s1_rdy <= '0;
      s2_rdy <= '0;
    end else begin
      for (int i = 0; i < `RS_SIZE; i++) begin
        if (tbl.grant[i]) begin
          // issued this cycle, entry goes back to the free pool
          valid[i] <= 1'b0;
        end else if (alloc_en && alloc_oh[i]) begin
          valid[i]  <= 1'b1;
          s1_rdy[i] <= dispatch_src1_ready | wake1_new;
          s2_rdy[i] <= dispatch_src2_ready | wake2_new;
        end else if (cdb_valid && valid[i]) begin
          // tag wakeup of waiting sources
          if (src1_q[i] == cdb_tag) begin
            s1_rdy[i] <= 1'b1;
          end
          if (src2_q[i] == cdb_tag) begin
            s2_rdy[i] <= 1'b1;
          end
        end
      end
    end
  end

  // payload written on allocation only
  always_ff @(posedge clock) begin
    for (int i = 0; i < `RS_SIZE; i++) begin
      if (alloc_en && alloc_oh[i]) begin
        op_q[i]   <= dispatch_opcode;
        dest_q[i] <= dispatch_dest;
        src1_q[i] <= dispatch_src1;
        src2_q[i] <= dispatch_src2;
      end
    end
  end

  // entry can issue once valid with both operands available
  assign tbl.ready  = valid & s1_rdy & s2_rdy;
  assign tbl.opcode = op_q;
  assign tbl.dest   = dest_q;
  assign tbl.src1   = src1_q;
  assign tbl.src2   = src2_q;

endmodule

/* verification/issue_props.sv */
`timescale 1ns/10ps
`include "issue_defs.svh"

module issue_props (
  input logic                                  clock,
  input logic                                  rst,
  input issue_pkg::rs_vec_t                    ready,
  input issue_pkg::rs_vec_t                    grant,
  input logic [`ISSUE_WIDTH-1:0][`RS_SIZE-1:0] lane_gnt,
  input issue_pkg::lane_vec_t                  issue_valid
);
  import issue_pkg::*;

  // ready entries this cycle, capped at the lane count
  logic [3:0] ready_cnt;
  logic [3:0] lanes_due;

  assign ready_cnt = 4'($countones(ready));
  assign lanes_due = (ready_cnt > `ISSUE_WIDTH) ? 4'(`ISSUE_WIDTH) : ready_cnt;

  for (genvar l = 0; l < `ISSUE_WIDTH; l++) begin : g_lane
    // a lane takes one entry or none
    a_lane_onehot: assert property (@(posedge clock) disable iff (rst)
      $onehot0(lane_gnt[l]))
      else $error("lane %0d grant has more than one bit set", l);

    // two lanes never share an entry
    for (genvar m = l + 1; m < `ISSUE_WIDTH; m++) begin : g_pair
      a_lane_disjoint: assert property (@(posedge clock) disable iff (rst)
        (lane_gnt[l] & lane_gnt[m]) == '0)
        else $error("lanes %0d and %0d grant the same entry", l, m);
    end
  end

  // only ready entries get granted
  a_grant_subset: assert property (@(posedge clock) disable iff (rst)
    (grant & ~ready) == '0)
    else $error("grant %b outside ready set %b", grant, ready);

  // issue register comes out of reset empty
  a_reset_idle: assert property (@(posedge clock)
    rst |=> issue_valid == '0)
    else $error("issue_valid %b after reset", issue_valid);

  // one valid lane per ready entry, up to the issue width
  a_lane_count: assert property (@(posedge clock) disable iff (rst)
    1'b1 |=> 4'($countones(issue_valid)) == $past(lanes_due))
    else $error("issue_valid %b does not match ready count", issue_valid);

endmodule

/* verification/issue_unit_tb.sv */
`timescale 1ns/10ps
`include "issue_defs.svh"

module issue_unit_tb;
  import issue_pkg::*;

  localparam int N = `RS_SIZE;
  localparam int L = `ISSUE_WIDTH;
  // cycles an entry may stay ready without being issued
  localparam int AGE_LIMIT  = 32;
  localparam int WAIT_LIMIT = 200;

  logic      clock;
  logic      rst;
  logic      dispatch_valid;
  opcode_t   dispatch_opcode;
  tag_t      dispatch_dest;
  tag_t      dispatch_src1;
  logic      dispatch_src1_ready;
  tag_t      dispatch_src2;
  logic      dispatch_src2_ready;
  logic      cdb_valid;
  tag_t      cdb_tag;
  logic      rs_full;
  lane_vec_t issue_valid;
  opcode_t   issue_opcode [L];
  tag_t      issue_dest   [L];
  tag_t      issue_src1   [L];
  tag_t      issue_src2   [L];

  // reference copy of the table
  logic    m_valid [N];
  logic    m_r1    [N];
  logic    m_r2    [N];
  opcode_t m_op    [N];
  tag_t    m_dest  [N];
  tag_t    m_src1  [N];
  tag_t    m_src2  [N];
  int      m_age   [N];
  int      m_count = 0;

  // lanes predicted at the last edge, seen on the outputs one cycle later
  logic    exp_valid [L];
  opcode_t exp_op    [L];
  tag_t    exp_dest  [L];
  tag_t    exp_src1  [L];
  tag_t    exp_src2  [L];

  int   accepted = 0;
  int   issued = 0;
  int   full_lane_cycles = 0;
  logic fail_seen = 1'b0;
  logic run_done = 1'b0;
  // source tags still waiting for their broadcast
  tag_t pending [$];

  tb_clock u_clock (.clock(clock));

  issue_unit_top uut (
    .clock (clock), .rst (rst),
    .dispatch_valid (dispatch_valid), .dispatch_opcode (dispatch_opcode),
    .dispatch_dest (dispatch_dest),
    .dispatch_src1 (dispatch_src1), .dispatch_src1_ready (dispatch_src1_ready),
    .dispatch_src2 (dispatch_src2), .dispatch_src2_ready (dispatch_src2_ready),
    .cdb_valid (cdb_valid), .cdb_tag (cdb_tag), .rs_full (rs_full),
    .issue_valid (issue_valid), .issue_opcode (issue_opcode), .issue_dest (issue_dest),
    .issue_src1 (issue_src1), .issue_src2 (issue_src2)
  );

  bind issue_select issue_props u_props (
    .clock (clock), .rst (rst), .ready (sel.ready), .grant (sel.grant),
    .lane_gnt (lane_gnt), .issue_valid (issue_valid)
  );

  task automatic check_val(input string name, input int got, input int exp);
    assert (got == exp) else begin
      fail_seen = 1'b1;
      $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_failure(input string what);
    fail_seen = 1'b1;
    $display("** Failure at %0t ns: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic wait_rs_full(input logic level);
    int n;
    n = 0;
    @(negedge clock);
    while (rs_full !== level && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (rs_full !== level) report_failure($sformatf("rs_full never went to %0b", level));
  endtask

  task automatic wait_table_empty();
    int n;
    n = 0;
    @(negedge clock);
    while (m_count != 0 && n < WAIT_LIMIT) begin
      @(negedge clock);
      n++;
    end
    if (m_count != 0) report_failure("entries left in the table after all wakeups");
  endtask

  // reference model, reads inputs and outputs as they stand before the edge
  always @(posedge clock) begin
    rs_vec_t taken;
    int      pick;
    int      slot;
    int      i;
    logic    full_now;
    if (rst) begin
      for (i = 0; i < N; i++) m_valid[i] = 1'b0;
      for (i = 0; i < L; i++) exp_valid[i] = 1'b0;
      m_count = 0;
    end else begin
      full_now = (m_count == N);
      check_val("rs_full", int'(rs_full), int'(full_now));
      // issue register loaded at the previous edge
      for (int l = 0; l < L; l++) begin
        check_val($sformatf("issue_valid[%0d]", l), int'(issue_valid[l]), int'(exp_valid[l]));
        if (exp_valid[l]) begin
          check_val($sformatf("issue_opcode[%0d]", l), int'(issue_opcode[l]), int'(exp_op[l]));
          check_val($sformatf("issue_dest[%0d]", l), int'(issue_dest[l]), int'(exp_dest[l]));
          check_val($sformatf("issue_src1[%0d]", l), int'(issue_src1[l]), int'(exp_src1[l]));
          check_val($sformatf("issue_src2[%0d]", l), int'(issue_src2[l]), int'(exp_src2[l]));
          issued++;
        end
      end
      if (issue_valid == '1) full_lane_cycles++;
      // lanes 0 and 2 take the lowest ready entry left, lane 1 the highest
      taken = '0;
      for (int l = 0; l < L; l++) begin
        pick = -1;
        for (int k = 0; k < N; k++) begin
          i = (l == 1) ? N - 1 - k : k;
          if (pick < 0 && m_valid[i] && m_r1[i] && m_r2[i] && !taken[i]) pick = i;
        end
        exp_valid[l] = (pick >= 0);
        if (pick >= 0) begin
          taken[pick] = 1'b1;
          exp_op[l]   = m_op[pick];
          exp_dest[l] = m_dest[pick];
          exp_src1[l] = m_src1[pick];
          exp_src2[l] = m_src2[pick];
        end
      end
      // free slot is chosen on the table before this edge
      slot = -1;
      for (i = N - 1; i >= 0; i--) if (!m_valid[i]) slot = i;
      for (i = 0; i < N; i++) begin
        if (taken[i]) begin
          m_valid[i] = 1'b0;
          m_count--;
        end else if (m_valid[i]) begin
          if (m_r1[i] && m_r2[i]) m_age[i]++;
          if (m_age[i] > AGE_LIMIT) report_failure($sformatf("entry %0d ready but not issued", i));
          if (cdb_valid && m_src1[i] == cdb_tag) m_r1[i] = 1'b1;
          if (cdb_valid && m_src2[i] == cdb_tag) m_r2[i] = 1'b1;
        end
      end
      // a dispatch while full is dropped
      if (dispatch_valid && !full_now) begin
        m_valid[slot] = 1'b1;
        m_op[slot]    = dispatch_opcode;
        m_dest[slot]  = dispatch_dest;
        m_src1[slot]  = dispatch_src1;
        m_src2[slot]  = dispatch_src2;
        m_r1[slot]    = dispatch_src1_ready || (cdb_valid && dispatch_src1 == cdb_tag);
        m_r2[slot]    = dispatch_src2_ready || (cdb_valid && dispatch_src2 == cdb_tag);
        m_age[slot]   = 0;
        m_count++;
        accepted++;
      end
    end
  end

  final begin
    // run stopped by a failing property
    if (!run_done && !fail_seen) $display("TEST FAILED");
  end

  initial begin
    int   idx;
    tag_t s1;
    tag_t s2;
    tag_t hold_tag;
    logic r1;
    logic r2;
    logic bcast;
    void'($urandom(32'h0812_7b4b));
    rst = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_opcode = '0;
    dispatch_dest = '0;
    dispatch_src1 = '0;
    dispatch_src1_ready = 1'b0;
    dispatch_src2 = '0;
    dispatch_src2_ready = 1'b0;
    cdb_valid = 1'b0;
    cdb_tag = '0;
    repeat (2) @(posedge clock);
    rst <= 1'b0;
    @(negedge clock);
    check_val("issue_valid", int'(issue_valid), 0);
    check_val("rs_full", int'(rs_full), 0);

    // random dispatch with partly unready sources and later broadcasts
    for (int n = 0; n < 400; n++) begin
      @(posedge clock);
      dispatch_valid <= 1'b0;
      cdb_valid      <= 1'b0;
      bcast = 1'b0;
      if ($urandom_range(3) != 0) begin
        s1 = tag_t'($urandom);
        s2 = tag_t'($urandom);
        r1 = ($urandom_range(1) == 1);
        r2 = ($urandom_range(1) == 1);
        dispatch_valid      <= 1'b1;
        dispatch_opcode     <= opcode_t'($urandom);
        dispatch_dest       <= tag_t'($urandom);
        dispatch_src1       <= s1;
        dispatch_src1_ready <= r1;
        dispatch_src2       <= s2;
        dispatch_src2_ready <= r2;
        if (!r1 && $urandom_range(3) == 0) begin
          // wakeup in the dispatch cycle itself
          bcast = 1'b1;
          cdb_valid <= 1'b1;
          cdb_tag   <= s1;
        end else if (!r1) begin
          pending.push_back(s1);
        end
        if (!r2) pending.push_back(s2);
      end
      if (!bcast && pending.size() > 0 && $urandom_range(2) == 0) begin
        idx = $urandom_range(pending.size() - 1);
        cdb_valid <= 1'b1;
        cdb_tag   <= pending[idx];
        pending.delete(idx);
      end
    end
    @(posedge clock);
    dispatch_valid <= 1'b0;
    cdb_valid      <= 1'b0;
    while (pending.size() > 0) begin
      @(posedge clock);
      cdb_valid <= 1'b1;
      cdb_tag   <= pending.pop_front();
    end
    @(posedge clock);
    cdb_valid <= 1'b0;
    wait_table_empty();

    // fill all entries behind one tag, then wake them together
    hold_tag = tag_t'(6'h2a);
    for (int n = 0; n < N; n++) begin
      @(posedge clock);
      dispatch_valid      <= 1'b1;
      dispatch_opcode     <= opcode_t'(n);
      dispatch_dest       <= tag_t'(n);
      dispatch_src1       <= hold_tag;
      dispatch_src1_ready <= 1'b0;
      dispatch_src2       <= tag_t'(n + 8);
      dispatch_src2_ready <= 1'b1;
    end
    @(posedge clock);
    dispatch_valid <= 1'b0;
    wait_rs_full(1'b1);
    // sent while full, must never issue
    @(posedge clock);
    dispatch_valid  <= 1'b1;
    dispatch_opcode <= opcode_t'(5'h1f);
    dispatch_dest   <= tag_t'(6'h3f);
    @(posedge clock);
    dispatch_valid <= 1'b0;
    cdb_valid      <= 1'b1;
    cdb_tag        <= hold_tag;
    @(posedge clock);
    cdb_valid <= 1'b0;
    wait_rs_full(1'b0);
    wait_table_empty();

    repeat (3) @(negedge clock);
    check_val("issued count", issued, accepted);
    if (full_lane_cycles < 2) report_failure("all three lanes were never valid twice");
    if (!fail_seen) begin
      run_done = 1'b1;
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "checks failed");
    end
  end

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
  parameter int HALF_PERIOD = 4
) (
  output logic clock
);

  // free running clock, 8 ns period with the default half period
  initial clock = 1'b0;

  always #(HALF_PERIOD) clock = ~clock;

endmodule
